// ==== cpuDecPkg.sv ====
// decoder field codes
package cpuDecPkg;

    localparam int STEP_W    = 4;
    localparam int REGSEL_W  = 3;
    localparam int DATASEL_W = 3;
    localparam int ADDRSEL_W = 2;
    localparam int ALUOP_W   = 2;

    localparam logic [STEP_W-1:0] STEP0 = STEP_W'(0);
    localparam logic [STEP_W-1:0] STEP1 = STEP_W'(1);
    localparam logic [STEP_W-1:0] STEP2 = STEP_W'(2);

    // register file codes.
    localparam logic [REGSEL_W-1:0] REG_A   = 3'd0;
    localparam logic [REGSEL_W-1:0] REG_B   = 3'd1;
    localparam logic [REGSEL_W-1:0] REG_H   = 3'd2;
    localparam logic [REGSEL_W-1:0] REG_L   = 3'd3;
    localparam logic [REGSEL_W-1:0] REG_IXL = 3'd4;
    localparam logic [REGSEL_W-1:0] REG_IXH = 3'd5;
    localparam logic [REGSEL_W-1:0] REG_IYL = 3'd6;
    localparam logic [REGSEL_W-1:0] REG_IYH = 3'd7;

    localparam logic [DATASEL_W-1:0] DT_NONE = 3'd0;
    localparam logic [DATASEL_W-1:0] DT_MEM  = 3'd1;
    localparam logic [DATASEL_W-1:0] DT_REG  = 3'd2;
    localparam logic [DATASEL_W-1:0] DT_IO   = 3'd3;
    localparam logic [DATASEL_W-1:0] DT_PCH  = 3'd4;
    localparam logic [DATASEL_W-1:0] DT_PCL  = 3'd5;

    localparam logic [ADDRSEL_W-1:0] AD_NONE    = 2'd0;
    localparam logic [ADDRSEL_W-1:0] AD_OPERAND = 2'd1;
    localparam logic [ADDRSEL_W-1:0] AD_SP      = 2'd2;

    localparam logic [ALUOP_W-1:0] ALU_NOP = 2'd0;
    localparam logic [ALUOP_W-1:0] ALU_ADD = 2'd1;
    localparam logic [ALUOP_W-1:0] ALU_SUB = 2'd2;

    // row 00xx1vvv, checked on bits 7, 6 and 3.
    localparam logic [7:0] ROW_MASK  = 8'hC8;
    localparam logic [7:0] ROW_MATCH = 8'h08;
    localparam logic       GRP_MEM   = 1'b0;  // bit 5.
    localparam logic [1:0] GRP_IO    = 2'b10; // bits 5:4.
    localparam logic [1:0] GRP_BR    = 2'b11;
    localparam logic [7:0] OP_CALL   = 8'h1F;

endpackage

// ==== ctrlBus.sv ====
// decoder control word bus
interface ctrlBus;

    logic endInstr;
    logic memRead;
    logic memWrite;
    logic ioIn;
    logic ioOut;
    logic decSp;
    logic pcLoad;
    logic regWrite;
    logic [cpuDecPkg::REGSEL_W-1:0]  regSel;
    logic [cpuDecPkg::DATASEL_W-1:0] dataSel;
    logic [cpuDecPkg::ADDRSEL_W-1:0] addrSel;
    logic [cpuDecPkg::ALUOP_W-1:0]   aluOp;

    modport src (
        output endInstr, memRead, memWrite, ioIn, ioOut, decSp, pcLoad, regWrite,
        output regSel, dataSel, addrSel, aluOp
    );

    modport sink (
        input endInstr, memRead, memWrite, ioIn, ioOut, decSp, pcLoad, regWrite,
        input regSel, dataSel, addrSel, aluOp
    );

endinterface

// ==== decodeBranchGroup.sv ====
// relative branch decoder
module decodeBranchGroup (
    input  logic                         enable,
    input  logic [7:0]                   opcode,
    input  logic [cpuDecPkg::STEP_W-1:0] step,
    input  logic                         flagC,
    input  logic                         flagZ,
    ctrlBus.src                          ctrl
);

    logic taken;

    always_comb begin
        case (opcode[1:0])
            2'd0:    taken = 1'b1;
            2'd1:    taken = flagC;
            2'd2:    taken = flagZ;
            default: taken = ~flagZ;
        endcase
    end

    always_comb begin
        ctrl.memRead  = 1'b0;
        ctrl.memWrite = 1'b0;
        ctrl.ioIn     = 1'b0;
        ctrl.ioOut    = 1'b0;
        ctrl.decSp    = 1'b0;
        ctrl.regWrite = 1'b0;
        ctrl.regSel   = '0;
        ctrl.dataSel  = cpuDecPkg::DT_NONE;
        ctrl.addrSel  = cpuDecPkg::AD_NONE;
        ctrl.aluOp    = cpuDecPkg::ALU_NOP;
        ctrl.pcLoad   = 1'b0;
        ctrl.endInstr = 1'b0;
        if (enable) begin
            if (!taken) begin
                ctrl.endInstr = 1'b1; // falls through.
            end else if (step == cpuDecPkg::STEP0) begin
                // bit 2 set branches backwards.
                ctrl.aluOp = opcode[2] ? cpuDecPkg::ALU_SUB : cpuDecPkg::ALU_ADD;
            end else if (step == cpuDecPkg::STEP1) begin
                ctrl.pcLoad   = 1'b1;
                ctrl.endInstr = 1'b1;
            end
        end
    end

endmodule

// ==== decodeChecker.sv ====
// decoder control word checker
module decodeChecker (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            instrValid,
    input  logic [7:0]                      instrIn,
    input  logic                            flagC,
    input  logic                            flagZ,
    input  logic                            ready,
    input  logic                            ctrlValid,
    input  logic                            endInstr,
    input  logic                            memRead,
    input  logic                            memWrite,
    input  logic                            ioIn,
    input  logic                            ioOut,
    input  logic                            decSp,
    input  logic                            pcLoad,
    input  logic                            regWrite,
    input  logic [cpuDecPkg::REGSEL_W-1:0]  regSel,
    input  logic [cpuDecPkg::DATASEL_W-1:0] dataSel,
    input  logic [cpuDecPkg::ADDRSEL_W-1:0] addrSel,
    input  logic [cpuDecPkg::ALUOP_W-1:0]   aluOp,
    output int                              errorCount,
    output int                              checkCount,
    output int                              acceptCount
);
    timeunit 1ns;
    timeprecision 1ps;

    logic        expBusy;
    int          expStep;
    logic [7:0]  curOp;
    logic        curC;
    logic        curZ;
    int          dutRun;
    int          lastCount;
    logic [17:0] gotWord;
    logic [17:0] expWord;

    // strobes first, then regSel, dataSel, addrSel, aluOp.
    assign gotWord = {endInstr, memRead, memWrite, ioIn, ioOut, decSp, pcLoad, regWrite,
                      regSel, dataSel, addrSel, aluOp};

    function automatic logic [17:0] expectWord(input logic [7:0] op, input int stepNo,
                                               input logic c, input logic z);
        logic                             endI;
        logic                             mRd;
        logic                             mWr;
        logic                             iIn;
        logic                             iOut;
        logic                             dSp;
        logic                             pcL;
        logic                             rWr;
        logic [cpuDecPkg::REGSEL_W-1:0]   rSel;
        logic [cpuDecPkg::DATASEL_W-1:0]  dSel;
        logic [cpuDecPkg::ADDRSEL_W-1:0]  aSel;
        logic [cpuDecPkg::ALUOP_W-1:0]    alu;
        logic                             taken;
        {endI, mRd, mWr, iIn, iOut, dSp, pcL, rWr} = 8'h00;
        rSel = op[2:0];
        dSel = cpuDecPkg::DT_NONE;
        aSel = cpuDecPkg::AD_NONE;
        alu  = cpuDecPkg::ALU_NOP;
        case (op[1:0])
            2'd0:    taken = 1'b1;
            2'd1:    taken = c;
            2'd2:    taken = z;
            default: taken = !z;
        endcase
        if (op[7:6] != 2'b00 || op[3] != 1'b1) begin
            endI = 1'b1; // outside the row.
        end else if (op[5] == 1'b0) begin
            if (op == 8'h1F) begin
                dSp = (stepNo < 2);
                aSel = (stepNo > 0) ? cpuDecPkg::AD_SP : cpuDecPkg::AD_NONE;
                dSel = (stepNo == 1) ? cpuDecPkg::DT_PCH :
                       (stepNo == 2) ? cpuDecPkg::DT_PCL : cpuDecPkg::DT_NONE;
                mWr  = (stepNo > 0);
                pcL  = (stepNo == 2);
                endI = (stepNo == 2);
            end else if (op[4]) begin
                aSel = cpuDecPkg::AD_OPERAND;
                dSel = cpuDecPkg::DT_REG;
                mWr  = 1'b1;
                endI = 1'b1;
            end else begin
                aSel = (stepNo == 0) ? cpuDecPkg::AD_OPERAND : cpuDecPkg::AD_NONE;
                mRd  = (stepNo == 0);
                rWr  = (stepNo == 1);
                dSel = (stepNo == 1) ? cpuDecPkg::DT_MEM : cpuDecPkg::DT_NONE;
                endI = (stepNo == 1);
            end
        end else if (op[4] == 1'b0) begin
            rSel = {1'b0, op[1:0]};
            dSel = op[2] ? cpuDecPkg::DT_REG : ((stepNo == 1) ? cpuDecPkg::DT_IO : dSel);
            iOut = op[2];
            iIn  = !op[2] && (stepNo == 0);
            rWr  = !op[2] && (stepNo == 1);
            endI = op[2] || (stepNo == 1);
        end else if (!taken) begin
            endI = 1'b1;
        end else begin
            alu  = (stepNo != 0) ? cpuDecPkg::ALU_NOP :
                   op[2] ? cpuDecPkg::ALU_SUB : cpuDecPkg::ALU_ADD;
            pcL  = (stepNo == 1);
            endI = (stepNo == 1);
        end
        // regSel only counts where a register is named.
        if (!(rWr || (mWr && dSel == cpuDecPkg::DT_REG) || iOut)) begin
            rSel = '0;
        end
        return {endI, mRd, mWr, iIn, iOut, dSp, pcL, rWr, rSel, dSel, aSel, alu};
    endfunction

    function automatic int stepCount(input logic [7:0] op, input logic c, input logic z);
        logic [17:0] w;
        int          n;
        n = 0;
        w = '0;
        while (n < 8 && !w[17]) begin
            w = expectWord(op, n, c, z);
            n++;
        end
        return n;
    endfunction

    task automatic logError(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        errorCount++;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            expBusy     = 1'b0;
            expStep     = 0;
            dutRun      = 0;
            lastCount   = 0;
            errorCount  = 0;
            checkCount  = 0;
            acceptCount = 0;
        end else begin
            checkCount++;
            expWord = expBusy ? expectWord(curOp, expStep, curC, curZ) : '0;
            if (ctrlValid !== expBusy) begin
                logError($sformatf("ctrlValid %b, expected %b", ctrlValid, expBusy));
            end
            if (ready !== !expBusy) begin
                logError($sformatf("ready %b, expected %b", ready, !expBusy));
            end
            if (gotWord !== expWord) begin
                logError($sformatf("op %02h step %0d word %05h, expected %05h",
                                   curOp, expStep, gotWord, expWord));
            end
            if (ctrlValid === 1'b1) begin
                dutRun++;
            end else if (dutRun != 0) begin
                if (dutRun != lastCount) begin
                    logError($sformatf("op %02h ran %0d steps, expected %0d",
                                       curOp, dutRun, lastCount));
                end
                dutRun = 0;
            end
            if (instrValid && ready) begin
                acceptCount++;
            end
            if (expBusy) begin
                if (expWord[17]) begin
                    expBusy = 1'b0;
                end else if (expStep >= 7) begin
                    logError("instruction never ended");
                    expBusy = 1'b0;
                end else begin
                    expStep++;
                end
            end else if (instrValid) begin
                curOp     = instrIn;
                curC      = flagC;
                curZ      = flagZ;
                expBusy   = 1'b1;
                expStep   = 0;
                lastCount = stepCount(instrIn, flagC, flagZ);
            end
        end
    end

endmodule

// ==== decodeIoGroup.sv ====
// port in and out decoder
module decodeIoGroup (
    input  logic                         enable,
    input  logic [7:0]                   opcode,
    input  logic [cpuDecPkg::STEP_W-1:0] step,
    ctrlBus.src                          ctrl
);

    logic isOut;

    assign isOut = opcode[2];

    always_comb begin
        ctrl.endInstr = 1'b0;
        ctrl.memRead  = 1'b0;
        ctrl.memWrite = 1'b0;
        ctrl.ioIn     = 1'b0;
        ctrl.ioOut    = 1'b0;
        ctrl.decSp    = 1'b0;
        ctrl.pcLoad   = 1'b0;
        ctrl.regWrite = 1'b0;
        ctrl.regSel   = '0;
        ctrl.dataSel  = cpuDecPkg::DT_NONE;
        ctrl.addrSel  = cpuDecPkg::AD_NONE;
        ctrl.aluOp    = cpuDecPkg::ALU_NOP;
        if (enable) begin
            if (isOut) begin
                ctrl.ioOut    = 1'b1;
                ctrl.dataSel  = cpuDecPkg::DT_REG;
                ctrl.regSel   = {1'b0, opcode[1:0]}; // only a, b, h, l.
                ctrl.endInstr = 1'b1;
            end else if (step == cpuDecPkg::STEP0) begin
                ctrl.ioIn = 1'b1;
            end else if (step == cpuDecPkg::STEP1) begin
                ctrl.regWrite = 1'b1;
                ctrl.regSel   = {1'b0, opcode[1:0]};
                ctrl.dataSel  = cpuDecPkg::DT_IO;
                ctrl.endInstr = 1'b1;
            end
        end
    end

endmodule

// ==== decodeMemGroup.sv ====
// load store and call decoder
module decodeMemGroup (
    input  logic                         enable,
    input  logic [7:0]                   opcode,
    input  logic [cpuDecPkg::STEP_W-1:0] step,
    ctrlBus.src                          ctrl
);

    logic                            isStore;
    logic [cpuDecPkg::REGSEL_W-1:0]  vvv;

    assign isStore = opcode[4];
    assign vvv     = opcode[2:0];

    always_comb begin
        ctrl.endInstr = 1'b0;
        ctrl.memRead  = 1'b0;
        ctrl.memWrite = 1'b0;
        ctrl.ioIn     = 1'b0;
        ctrl.ioOut    = 1'b0;
        ctrl.decSp    = 1'b0;
        ctrl.pcLoad   = 1'b0;
        ctrl.regWrite = 1'b0;
        ctrl.regSel   = '0;
        ctrl.dataSel  = cpuDecPkg::DT_NONE;
        ctrl.addrSel  = cpuDecPkg::AD_NONE;
        ctrl.aluOp    = cpuDecPkg::ALU_NOP;
        if (enable) begin
            if (opcode == cpuDecPkg::OP_CALL) begin
                // push pch then pcl, then jump.
                ctrl.decSp = (step == cpuDecPkg::STEP0) || (step == cpuDecPkg::STEP1);
                if (step == cpuDecPkg::STEP1) begin
                    ctrl.addrSel  = cpuDecPkg::AD_SP;
                    ctrl.dataSel  = cpuDecPkg::DT_PCH;
                    ctrl.memWrite = 1'b1;
                end else if (step == cpuDecPkg::STEP2) begin
                    ctrl.addrSel  = cpuDecPkg::AD_SP;
                    ctrl.dataSel  = cpuDecPkg::DT_PCL;
                    ctrl.memWrite = 1'b1;
                    ctrl.pcLoad   = 1'b1;
                    ctrl.endInstr = 1'b1;
                end
            end else if (isStore) begin
                ctrl.addrSel  = cpuDecPkg::AD_OPERAND;
                ctrl.dataSel  = cpuDecPkg::DT_REG;
                ctrl.regSel   = vvv;
                ctrl.memWrite = 1'b1;
                ctrl.endInstr = 1'b1; // single step.
            end else if (step == cpuDecPkg::STEP0) begin
                ctrl.addrSel = cpuDecPkg::AD_OPERAND;
                ctrl.memRead = 1'b1;
            end else if (step == cpuDecPkg::STEP1) begin
                ctrl.regWrite = 1'b1;
                ctrl.regSel   = vvv;
                ctrl.dataSel  = cpuDecPkg::DT_MEM;
                ctrl.endInstr = 1'b1;
            end
        end
    end

endmodule

// ==== decodeRow.sv ====
// decoder row 00xx1vvv
module decodeRow (
    input  logic                         busy,
    input  logic [7:0]                   opcode,
    input  logic [cpuDecPkg::STEP_W-1:0] step,
    input  logic                         flagC,
    input  logic                         flagZ,
    ctrlBus.src                          ctrl
);

    logic rowHit;
    logic memEn;
    logic ioEn;
    logic brEn;
    logic nopEnd;

    ctrlBus memBus ();
    ctrlBus ioBus ();
    ctrlBus brBus ();

    assign rowHit = busy && ((opcode & cpuDecPkg::ROW_MASK) == cpuDecPkg::ROW_MATCH);
    assign memEn  = rowHit && (opcode[5] == cpuDecPkg::GRP_MEM);
    assign ioEn   = rowHit && (opcode[5:4] == cpuDecPkg::GRP_IO);
    assign brEn   = rowHit && (opcode[5:4] == cpuDecPkg::GRP_BR);
    assign nopEnd = busy && !rowHit; // foreign opcode, one step.

    decodeMemGroup decodeMemGroup_inst (
        .enable (memEn),
        .opcode (opcode),
        .step   (step),
        .ctrl   (memBus.src)
    );

    decodeIoGroup decodeIoGroup_inst (
        .enable (ioEn),
        .opcode (opcode),
        .step   (step),
        .ctrl   (ioBus.src)
    );

    decodeBranchGroup decodeBranchGroup_inst (
        .enable (brEn),
        .opcode (opcode),
        .step   (step),
        .flagC  (flagC),
        .flagZ  (flagZ),
        .ctrl   (brBus.src)
    );

    // only one group is live, so or is exact.
    assign ctrl.endInstr = memBus.endInstr | ioBus.endInstr | brBus.endInstr | nopEnd;
    assign ctrl.memRead  = memBus.memRead | ioBus.memRead | brBus.memRead;
    assign ctrl.memWrite = memBus.memWrite | ioBus.memWrite | brBus.memWrite;
    assign ctrl.ioIn     = memBus.ioIn | ioBus.ioIn | brBus.ioIn;
    assign ctrl.ioOut    = memBus.ioOut | ioBus.ioOut | brBus.ioOut;
    assign ctrl.decSp    = memBus.decSp | ioBus.decSp | brBus.decSp;
    assign ctrl.pcLoad   = memBus.pcLoad | ioBus.pcLoad | brBus.pcLoad;
    assign ctrl.regWrite = memBus.regWrite | ioBus.regWrite | brBus.regWrite;
    assign ctrl.regSel   = memBus.regSel | ioBus.regSel | brBus.regSel;
    assign ctrl.dataSel  = memBus.dataSel | ioBus.dataSel | brBus.dataSel;
    assign ctrl.addrSel  = memBus.addrSel | ioBus.addrSel | brBus.addrSel;
    assign ctrl.aluOp    = memBus.aluOp | ioBus.aluOp | brBus.aluOp;

endmodule

// ==== decoderTop.sv ====
// instruction decode top
module decoderTop (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            instrValid,
    input  logic [7:0]                      instrIn,
    input  logic                            flagC,
    input  logic                            flagZ,
    output logic                            ready,
    output logic                            ctrlValid,
    output logic                            endInstr,
    output logic                            memRead,
    output logic                            memWrite,
    output logic                            ioIn,
    output logic                            ioOut,
    output logic                            decSp,
    output logic                            pcLoad,
    output logic                            regWrite,
    output logic [cpuDecPkg::REGSEL_W-1:0]  regSel,
    output logic [cpuDecPkg::DATASEL_W-1:0] dataSel,
    output logic [cpuDecPkg::ADDRSEL_W-1:0] addrSel,
    output logic [cpuDecPkg::ALUOP_W-1:0]   aluOp
);

    logic                         busy;
    logic [7:0]                   opcode;
    logic [cpuDecPkg::STEP_W-1:0] step;

    ctrlBus rowBus ();

    instrSequencer instrSequencer_inst (
        .clk        (clk),
        .rst        (rst),
        .instrValid (instrValid),
        .instrIn    (instrIn),
        .endInstr   (rowBus.endInstr),
        .ready      (ready),
        .busy       (busy),
        .opcode     (opcode),
        .step       (step)
    );

    decodeRow decodeRow_inst (
        .busy   (busy),
        .opcode (opcode),
        .step   (step),
        .flagC  (flagC),
        .flagZ  (flagZ),
        .ctrl   (rowBus.src)
    );

    assign ctrlValid = busy; // one word per busy cycle.
    assign endInstr  = rowBus.endInstr;
    assign memRead   = rowBus.memRead;
    assign memWrite  = rowBus.memWrite;
    assign ioIn      = rowBus.ioIn;
    assign ioOut     = rowBus.ioOut;
    assign decSp     = rowBus.decSp;
    assign pcLoad    = rowBus.pcLoad;
    assign regWrite  = rowBus.regWrite;
    assign regSel    = rowBus.regSel;
    assign dataSel   = rowBus.dataSel;
    assign addrSel   = rowBus.addrSel;
    assign aluOp     = rowBus.aluOp;

endmodule

// ==== instrSequencer.sv ====
// instruction and step registers
module instrSequencer (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         instrValid,
    input  logic [7:0]                   instrIn,
    input  logic                         endInstr,
    output logic                         ready,
    output logic                         busy,
    output logic [7:0]                   opcode,
    output logic [cpuDecPkg::STEP_W-1:0] step
);

    logic accept;

    assign accept = instrValid && !busy;
    assign ready  = ~busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            step <= '0;
        end else if (accept) begin
            busy <= 1'b1;
            step <= '0;
        end else if (busy) begin
            if (endInstr) begin
                busy <= 1'b0; // last step done.
            end else begin
                step <= step + 1'b1;
            end
        end
    end

    // opcode only matters while busy.
    always_ff @(posedge clk) begin
        if (accept) begin
            opcode <= instrIn;
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# build the decoder testbench with Verilator, run it, and check the log
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module tbTop -f tb.f -o tbSim \
    && ./obj_dir/tbSim | tee sim.log \
    && grep -qx "Test completed successfully" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== tb.f ====
cpuDecPkg.sv
ctrlBus.sv
instrSequencer.sv
decodeMemGroup.sv
decodeIoGroup.sv
decodeBranchGroup.sv
decodeRow.sv
decoderTop.sv
decodeChecker.sv
tbTop.sv

// ==== tbTop.sv ====
// decoder testbench top
module tbTop;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_RANDOM = 200;
    localparam int NUM_OPS    = 16 + 8 + 32 + NUM_RANDOM;

    logic                            clk;
    logic                            rst;
    logic                            instrValid;
    logic [7:0]                      instrIn;
    logic                            flagC;
    logic                            flagZ;
    logic                            ready;
    logic                            ctrlValid;
    logic                            endInstr;
    logic                            memRead;
    logic                            memWrite;
    logic                            ioIn;
    logic                            ioOut;
    logic                            decSp;
    logic                            pcLoad;
    logic                            regWrite;
    logic [cpuDecPkg::REGSEL_W-1:0]  regSel;
    logic [cpuDecPkg::DATASEL_W-1:0] dataSel;
    logic [cpuDecPkg::ADDRSEL_W-1:0] addrSel;
    logic [cpuDecPkg::ALUOP_W-1:0]   aluOp;
    int                              errorCount;
    int                              checkCount;
    int                              acceptCount;

    decoderTop decoderTop_inst (
        .clk(clk), .rst(rst), .instrValid(instrValid), .instrIn(instrIn),
        .flagC(flagC), .flagZ(flagZ), .ready(ready), .ctrlValid(ctrlValid),
        .endInstr(endInstr), .memRead(memRead), .memWrite(memWrite), .ioIn(ioIn),
        .ioOut(ioOut), .decSp(decSp), .pcLoad(pcLoad), .regWrite(regWrite),
        .regSel(regSel), .dataSel(dataSel), .addrSel(addrSel), .aluOp(aluOp)
    );

    decodeChecker decodeChecker_inst (
        .clk(clk), .rst(rst), .instrValid(instrValid), .instrIn(instrIn),
        .flagC(flagC), .flagZ(flagZ), .ready(ready), .ctrlValid(ctrlValid),
        .endInstr(endInstr), .memRead(memRead), .memWrite(memWrite), .ioIn(ioIn),
        .ioOut(ioOut), .decSp(decSp), .pcLoad(pcLoad), .regWrite(regWrite),
        .regSel(regSel), .dataSel(dataSel), .addrSel(addrSel), .aluOp(aluOp),
        .errorCount(errorCount), .checkCount(checkCount), .acceptCount(acceptCount)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // offer one opcode, optionally keep valid up one more cycle with another one.
    task automatic issueOp(input logic [7:0] op, input logic c, input logic z,
                           input logic lateOffer);
        while (!ready) @(negedge clk);
        instrValid = 1'b1;
        instrIn    = op;
        flagC      = c;
        flagZ      = z;
        @(negedge clk);
        if (lateOffer) begin
            instrIn = ~op; // busy now, must be dropped.
            @(negedge clk);
        end
        instrValid = 1'b0;
    endtask

    initial begin
        repeat (NUM_OPS * 10 + 100) @(posedge clk);
        $display("run timed out, the DUT stopped finishing instructions");
        $display("Test failed");
        $finish;
    end

    initial begin
        int         i;
        int         f;
        logic [7:0] op;
        rst        = 1'b1;
        instrValid = 1'b0;
        instrIn    = 8'h00;
        flagC      = 1'b0;
        flagZ      = 1'b0;
        void'($urandom(50));
        repeat (4) @(negedge clk);
        rst = 1'b0;
        repeat (2) @(negedge clk); // idle words after reset.
        for (i = 0; i < 16; i++) begin
            op = {3'b000, i[3], 1'b1, i[2:0]};
            issueOp(op, 1'($urandom_range(0, 1)), 1'($urandom_range(0, 1)), i[0]);
        end
        for (i = 0; i < 8; i++) begin
            issueOp({5'b00101, i[2:0]}, 1'b0, 1'b0, i[1]);
        end
        for (i = 0; i < 8; i++) begin
            for (f = 0; f < 4; f++) begin
                issueOp({5'b00111, i[2:0]}, f[0], f[1], 1'b0);
            end
        end
        for (i = 0; i < NUM_RANDOM; i++) begin
            op = 8'($urandom());
            if ($urandom_range(0, 1) == 1) begin
                op[7:6] = 2'b00; // pull about half into the row.
                op[3]   = 1'b1;
            end
            issueOp(op, 1'($urandom_range(0, 1)), 1'($urandom_range(0, 1)),
                    $urandom_range(0, 3) == 0);
        end
        while (!ready) @(negedge clk);
        repeat (3) @(negedge clk);
        if (acceptCount != NUM_OPS) begin
            $display("DUT accepted %0d instructions where %0d were offered while ready",
                     acceptCount, NUM_OPS);
        end
        $display("checks %0d, errors %0d, accepted %0d of %0d",
                 checkCount, errorCount, acceptCount, NUM_OPS);
        if (errorCount == 0 && acceptCount == NUM_OPS) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
